// File: ptw_macros.svh
`ifndef PTW_MACROS_SVH
`define PTW_MACROS_SVH

// ====================
// Widths and counts
// ====================
`define BUS_DATA_WIDTH 64
`define BUS_TAG_WIDTH  13
`define LINE_BEATS     8
`define WALK_LEVELS    3

// Tag field codes, command at tag bit 12 and target in tag bits 11 to 8
`define SYSBUS_READ    1'b1
`define SYSBUS_MEMORY  4'b0001

`endif

// File: mmu_pkg.sv
`include "ptw_macros.svh"

package mmu_pkg;

    // Only bits 38 to 0 of a virtual address take part in translation
    typedef logic [`BUS_DATA_WIDTH-1:0] vaddr_t;
    typedef logic [`BUS_DATA_WIDTH-1:0] paddr_t;

    typedef logic [8:0] vpn_t;

    // Valid in bit 0, physical page number in bits 53 to 10
    typedef logic [`BUS_DATA_WIDTH-1:0] pte_t;

    typedef logic [$clog2(`LINE_BEATS)-1:0] beat_idx_t;
    typedef logic [1:0] level_t;

    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_FETCH,
        WALK_COLLECT,
        WALK_FINISH
    } walk_state_t;

endpackage

// File: sysbus_pkg.sv
`include "ptw_macros.svh"

package sysbus_pkg;

    typedef logic [`BUS_TAG_WIDTH-1:0] bus_tag_t;

    typedef enum logic {
        BUS_CMD_WRITE = 1'b0,
        BUS_CMD_READ  = `SYSBUS_READ
    } bus_cmd_t;

    typedef enum logic [3:0] {
        BUS_TGT_MEMORY = `SYSBUS_MEMORY,
        BUS_TGT_IO     = 4'b0010
    } bus_target_t;

    typedef enum logic [2:0] {
        PORT_IDLE,
        PORT_ARBITRATE,
        PORT_REQUEST,
        PORT_WAIT_RESP,
        PORT_RECEIVE
    } port_state_t;

endpackage

// File: walk_request_latch.sv
`timescale 1ns/1ps

module walk_request_latch (
    input  logic            clk,
    input  logic            reset,
    input  logic            translate_req,
    input  mmu_pkg::vaddr_t virt_addr,
    input  mmu_pkg::paddr_t ptbr,
    input  logic            walk_end,
    output logic            busy,
    output logic            walk_start,
    output mmu_pkg::vaddr_t walk_vaddr,
    output mmu_pkg::paddr_t walk_base
);
    logic accept;

    // A strobe that comes while a walk is running is dropped here
    assign accept = translate_req && !busy;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy       <= 1'b0;
            walk_start <= 1'b0;
        end
        else
        begin
            walk_start <= accept;
            if (accept)
                busy <= 1'b1;
            else if (walk_end)
                busy <= 1'b0;
        end
    end

    // Held for the whole walk so the requester may move on at once
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            walk_vaddr <= virt_addr;
            walk_base  <= ptbr;
        end
    end

endmodule

// File: page_walker.sv
`timescale 1ns/1ps
`include "ptw_macros.svh"

module page_walker (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            walk_start,
    input  mmu_pkg::vaddr_t                 walk_vaddr,
    input  mmu_pkg::paddr_t                 walk_base,
    input  logic                            beat_valid,
    input  mmu_pkg::beat_idx_t              beat_idx,
    input  mmu_pkg::pte_t                   beat_data,
    input  logic                            line_done,
    output logic                            line_rd,
    output mmu_pkg::paddr_t                 line_addr,
    output logic                            walk_end,
    output logic                            walk_done,
    output logic                            walk_fault,
    output mmu_pkg::paddr_t                 phys_addr,
    output mmu_pkg::pte_t [`LINE_BEATS-1:0] pte_line
);
    import mmu_pkg::*;

    walk_state_t state;
    level_t      level_q;
    paddr_t      base_q;
    pte_t        kept_q;
    logic        done_q;

    vpn_t        vpn;
    paddr_t      entry_addr;
    beat_idx_t   sel_idx;
    logic        sel_hit;
    pte_t        sel_entry;
    paddr_t      next_base;
    logic        last_level;
    logic        deciding;

    // ====================
    // Entry addressing
    // ====================
    always_comb
    begin
        case (level_q)
            2'd1:    vpn = walk_vaddr[38:30];
            2'd2:    vpn = walk_vaddr[29:21];
            default: vpn = walk_vaddr[20:12];
        endcase
    end

    assign entry_addr = base_q + paddr_t'({vpn, 3'b000});
    assign sel_idx    = entry_addr[5:3];
    assign line_addr  = {entry_addr[63:6], 6'b000000};
    assign line_rd    = (state == WALK_FETCH);
    assign last_level = (level_q == level_t'(`WALK_LEVELS));

    // The wanted entry may arrive on the same beat as line_done
    assign sel_hit   = beat_valid && (beat_idx == sel_idx);
    assign sel_entry = sel_hit ? beat_data : kept_q;
    assign next_base = {8'h00, sel_entry[53:10], 12'h000};
    assign deciding  = line_done && (last_level || !sel_entry[0]);

    assign walk_done = done_q;
    assign walk_end  = done_q;

    // ====================
    // Level sequencing
    // ====================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= WALK_IDLE;
            level_q    <= '0;
            done_q     <= 1'b0;
            walk_fault <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (state)
                WALK_IDLE:
                begin
                    if (walk_start)
                    begin
                        level_q <= level_t'(1);
                        state   <= WALK_FETCH;
                    end
                end
                WALK_FETCH:
                begin
                    state <= WALK_COLLECT;
                end
                WALK_COLLECT:
                begin
                    if (deciding)
                    begin
                        done_q     <= 1'b1;
                        walk_fault <= !sel_entry[0];
                        state      <= WALK_FINISH;
                    end
                    else if (line_done)
                    begin
                        level_q <= level_q + level_t'(1);
                        state   <= WALK_FETCH;
                    end
                end
                WALK_FINISH:
                begin
                    state <= WALK_IDLE;
                end
                default:
                begin
                    state <= WALK_IDLE;
                end
            endcase
        end
    end

    // ====================
    // Data path
    // ====================
    always_ff @(posedge clk)
    begin
        if (state == WALK_IDLE && walk_start)
            base_q <= walk_base;
        else if (line_done && !deciding)
            base_q <= next_base;

        if (sel_hit)
            kept_q <= beat_data;

        // The whole last-level line is kept in beat order
        if (beat_valid && last_level)
            pte_line[beat_idx] <= beat_data;

        if (line_done && last_level && sel_entry[0])
            phys_addr <= next_base + paddr_t'(walk_vaddr[11:0]);
    end

endmodule

// File: sysbus_port.sv
`timescale 1ns/1ps
`include "ptw_macros.svh"

module sysbus_port (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       line_rd,
    input  mmu_pkg::paddr_t            line_addr,
    input  logic                       abtr_grant,
    input  logic                       main_bus_respcyc,
    input  logic [`BUS_DATA_WIDTH-1:0] main_bus_resp,
    input  sysbus_pkg::bus_tag_t       main_bus_resptag,
    output logic                       abtr_reqcyc,
    output logic                       bus_busy,
    output logic                       main_bus_reqcyc,
    output logic [`BUS_DATA_WIDTH-1:0] main_bus_req,
    output sysbus_pkg::bus_tag_t       main_bus_reqtag,
    output logic                       main_bus_respack,
    output logic                       beat_valid,
    output mmu_pkg::beat_idx_t         beat_idx,
    output mmu_pkg::pte_t              beat_data,
    output logic                       line_done
);
    import sysbus_pkg::*;
    import mmu_pkg::*;

    localparam bus_tag_t READ_TAG = {BUS_CMD_READ, BUS_TGT_MEMORY, 8'h00};

    port_state_t state;
    paddr_t      addr_q;
    beat_idx_t   beat_cnt;
    logic        accept;

    // Beats with a foreign tag belong to another master
    assign accept = main_bus_respcyc && (main_bus_resptag == READ_TAG)
                 && (state == PORT_WAIT_RESP || state == PORT_RECEIVE);

    assign abtr_reqcyc      = (state == PORT_ARBITRATE);
    assign main_bus_reqcyc  = (state == PORT_REQUEST);
    assign bus_busy         = (state == PORT_REQUEST) || (state == PORT_WAIT_RESP)
                           || (state == PORT_RECEIVE);
    assign main_bus_req     = main_bus_reqcyc ? addr_q : '0;
    assign main_bus_reqtag  = main_bus_reqcyc ? READ_TAG : '0;
    assign main_bus_respack = accept;

    assign beat_valid = accept;
    assign beat_idx   = beat_cnt;
    assign beat_data  = main_bus_resp;
    assign line_done  = accept && (beat_cnt == beat_idx_t'(`LINE_BEATS - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= PORT_IDLE;
            beat_cnt <= '0;
        end
        else
        begin
            if (accept)
                beat_cnt <= beat_cnt + beat_idx_t'(1);
            case (state)
                PORT_IDLE:      if (line_rd) state <= PORT_ARBITRATE;
                PORT_ARBITRATE: if (abtr_grant) state <= PORT_REQUEST;
                PORT_REQUEST:
                begin
                    beat_cnt <= '0;
                    state    <= PORT_WAIT_RESP;
                end
                PORT_WAIT_RESP: if (accept) state <= line_done ? PORT_IDLE : PORT_RECEIVE;
                PORT_RECEIVE:   if (line_done) state <= PORT_IDLE;
                default:        state <= PORT_IDLE;
            endcase
        end
    end

    // Line address captured once per read strobe
    always_ff @(posedge clk)
    begin
        if (state == PORT_IDLE && line_rd)
            addr_q <= line_addr;
    end

endmodule

// File: ptw_top.sv
`timescale 1ns/1ps
`include "ptw_macros.svh"

module ptw_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            translate_req,
    input  mmu_pkg::vaddr_t                 virt_addr,
    input  mmu_pkg::paddr_t                 ptbr,
    output logic                            busy,
    output logic                            walk_done,
    output logic                            walk_fault,
    output mmu_pkg::paddr_t                 phys_addr,
    output mmu_pkg::pte_t [`LINE_BEATS-1:0] pte_line,
    input  logic                            abtr_grant,
    output logic                            abtr_reqcyc,
    output logic                            bus_busy,
    output logic                            main_bus_reqcyc,
    output logic [`BUS_DATA_WIDTH-1:0]      main_bus_req,
    output sysbus_pkg::bus_tag_t            main_bus_reqtag,
    input  logic                            main_bus_respcyc,
    input  logic [`BUS_DATA_WIDTH-1:0]      main_bus_resp,
    input  sysbus_pkg::bus_tag_t            main_bus_resptag,
    output logic                            main_bus_respack
);
    import mmu_pkg::*;

    logic      walk_start;
    logic      walk_end;
    vaddr_t    walk_vaddr;
    paddr_t    walk_base;
    logic      line_rd;
    paddr_t    line_addr;
    logic      beat_valid;
    beat_idx_t beat_idx;
    pte_t      beat_data;
    logic      line_done;

    walk_request_latch latch_i (
        .clk, .reset, .translate_req, .virt_addr, .ptbr, .walk_end,
        .busy, .walk_start, .walk_vaddr, .walk_base
    );

    page_walker walker_i (
        .clk, .reset, .walk_start, .walk_vaddr, .walk_base,
        .beat_valid, .beat_idx, .beat_data, .line_done,
        .line_rd, .line_addr, .walk_end, .walk_done, .walk_fault,
        .phys_addr, .pte_line
    );

    sysbus_port port_i (
        .clk, .reset, .line_rd, .line_addr, .abtr_grant,
        .main_bus_respcyc, .main_bus_resp, .main_bus_resptag,
        .abtr_reqcyc, .bus_busy, .main_bus_reqcyc, .main_bus_req, .main_bus_reqtag,
        .main_bus_respack, .beat_valid, .beat_idx, .beat_data, .line_done
    );

endmodule

// File: ptw_sva.sv
`timescale 1ns/1ps

module ptw_sva (
    input logic clk,
    input logic reset,
    input logic abtr_grant,
    input logic abtr_reqcyc,
    input logic bus_busy,
    input logic main_bus_reqcyc,
    input logic main_bus_respcyc,
    input logic main_bus_respack
);
    int unsigned fail_count = 0;

    // ====================
    // Request side
    // ====================
    reqcyc_single: assert property (@(posedge clk) disable iff (reset)
        main_bus_reqcyc |=> !main_bus_reqcyc)
    else
    begin
        $error("main_bus_reqcyc stayed high for more than one cycle");
        fail_count++;
    end

    reqcyc_after_grant: assert property (@(posedge clk) disable iff (reset)
        main_bus_reqcyc |-> $past(abtr_grant) && $past(abtr_reqcyc))
    else
    begin
        $error("main_bus_reqcyc without a grant in the cycle before");
        fail_count++;
    end

    arb_and_req_apart: assert property (@(posedge clk) disable iff (reset)
        !(abtr_reqcyc && main_bus_reqcyc))
    else
    begin
        $error("abtr_reqcyc and main_bus_reqcyc high together");
        fail_count++;
    end

    // ====================
    // Response side
    // ====================
    ack_with_resp: assert property (@(posedge clk) disable iff (reset)
        main_bus_respack |-> main_bus_respcyc)
    else
    begin
        $error("main_bus_respack without main_bus_respcyc");
        fail_count++;
    end

    // Everything the port drives is quiet once a reset cycle has passed
    quiet_after_reset: assert property (@(posedge clk)
        $past(reset) |-> !(bus_busy || abtr_reqcyc || main_bus_reqcyc || main_bus_respack))
    else
    begin
        $error("bus port outputs not low after reset");
        fail_count++;
    end

endmodule

bind sysbus_port ptw_sva sva_i (
    .clk              (clk),
    .reset            (reset),
    .abtr_grant       (abtr_grant),
    .abtr_reqcyc      (abtr_reqcyc),
    .bus_busy         (bus_busy),
    .main_bus_reqcyc  (main_bus_reqcyc),
    .main_bus_respcyc (main_bus_respcyc),
    .main_bus_respack (main_bus_respack)
);

// File: ptw_checker.sv
`timescale 1ns/1ps
`include "ptw_macros.svh"

module ptw_checker (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            translate_req,
    input  mmu_pkg::vaddr_t                 virt_addr,
    input  mmu_pkg::paddr_t                 ptbr,
    input  logic                            busy,
    input  logic                            walk_done,
    input  logic                            walk_fault,
    input  mmu_pkg::paddr_t                 phys_addr,
    input  mmu_pkg::pte_t [`LINE_BEATS-1:0] pte_line,
    input  logic                            abtr_grant,
    input  logic                            bus_busy,
    input  logic                            main_bus_reqcyc,
    input  logic [`BUS_DATA_WIDTH-1:0]      main_bus_req,
    input  sysbus_pkg::bus_tag_t            main_bus_reqtag,
    input  logic                            main_bus_respcyc,
    input  sysbus_pkg::bus_tag_t            main_bus_resptag,
    input  logic                            main_bus_respack,
    output int                              error_count
);
    import mmu_pkg::*;
    import sysbus_pkg::*;

    localparam bus_tag_t READ_TAG = {`SYSBUS_READ, `SYSBUS_MEMORY, 8'h00};

    int     errors     = 0;
    logic   pending    = 1'b0;
    logic   reset_q    = 1'b0;
    logic   check_busy = 1'b0;
    logic   line_open  = 1'b0;
    int     beats_seen;
    int     levels;
    int     req_count;
    logic   exp_fault;
    paddr_t exp_phys;
    paddr_t exp_line [`WALK_LEVELS];
    pte_t   exp_pte  [`LINE_BEATS];

    assign error_count = errors;

    task automatic report(input string msg);
        $display("ERR @%0t: %s", $time, msg);
        errors++;
    endtask

    // Reference walk over the testbench page table memory
    task automatic model_walk(input vaddr_t va, input paddr_t root);
        paddr_t base;
        paddr_t entry_addr;
        pte_t   entry;
        vpn_t   vpn;
        int     lvl;
        int     i;
        logic   stop;
        base      = root;
        stop      = 1'b0;
        levels    = 0;
        exp_fault = 1'b0;
        for (lvl = 1; lvl <= `WALK_LEVELS; lvl++)
        begin
            if (!stop)
            begin
                vpn = (lvl == 1) ? va[38:30] : (lvl == 2) ? va[29:21] : va[20:12];
                entry_addr        = base + paddr_t'({vpn, 3'b000});
                exp_line[lvl - 1] = {entry_addr[63:6], 6'b000000};
                entry             = ptw_tb.page_mem[entry_addr];
                levels            = lvl;
                if (!entry[0])
                begin
                    exp_fault = 1'b1;
                    stop      = 1'b1;
                end
                else
                    base = paddr_t'(entry[53:10]) << 12;
            end
        end
        exp_phys = base + paddr_t'(va[11:0]);
        if (levels == `WALK_LEVELS)
        begin
            for (i = 0; i < `LINE_BEATS; i++)
                exp_pte[i] = ptw_tb.page_mem[exp_line[`WALK_LEVELS-1] + paddr_t'(i * 8)];
        end
    endtask

    task automatic compare_result();
        int i;
        if (req_count != levels)
            report($sformatf("%0d bus requests in the walk, expected %0d", req_count, levels));
        if (walk_fault != exp_fault)
            report($sformatf("walk_fault %b, expected %b", walk_fault, exp_fault));
        if (!exp_fault && phys_addr != exp_phys)
            report($sformatf("phys_addr %h, expected %h", phys_addr, exp_phys));
        // The last-level line is only complete when the walk got that far
        if (levels == `WALK_LEVELS)
        begin
            for (i = 0; i < `LINE_BEATS; i++)
            begin
                if (pte_line[i] != exp_pte[i])
                    report($sformatf("pte_line[%0d] %h, expected %h", i, pte_line[i], exp_pte[i]));
            end
        end
    endtask

    always @(posedge clk)
    begin
        if (reset_q && (busy || walk_done))
            report("busy or walk_done high after reset");
        if (reset)
        begin
            pending    = 1'b0;
            check_busy = 1'b0;
            line_open  = 1'b0;
        end
        else
        begin
            if (check_busy && busy)
                report("busy still high in the cycle after walk_done");
            check_busy = 1'b0;

            // The bus stays claimed from the cycle after the grant to the last beat
            if (bus_busy != line_open)
                report($sformatf("bus_busy %b, expected %b", bus_busy, line_open));
            if (abtr_grant)
            begin
                line_open  = 1'b1;
                beats_seen = 0;
            end
            else if (line_open && main_bus_respcyc && main_bus_resptag == READ_TAG)
            begin
                beats_seen++;
                if (beats_seen == `LINE_BEATS)
                    line_open = 1'b0;
            end

            if (translate_req && !busy)
            begin
                model_walk(virt_addr, ptbr);
                pending   = 1'b1;
                req_count = 0;
            end

            if (main_bus_reqcyc)
            begin
                if (!pending || req_count >= levels)
                    report("bus request beyond the expected walk");
                else
                begin
                    if (main_bus_req != exp_line[req_count])
                        report($sformatf("bus request address %h, expected %h",
                                         main_bus_req, exp_line[req_count]));
                    if (main_bus_reqtag != READ_TAG)
                        report($sformatf("bus request tag %h, expected %h",
                                         main_bus_reqtag, READ_TAG));
                end
                req_count++;
            end

            if (main_bus_respcyc && main_bus_resptag != READ_TAG && main_bus_respack)
                report($sformatf("beat with foreign tag %h acknowledged", main_bus_resptag));
            if (main_bus_respcyc && main_bus_resptag == READ_TAG && !main_bus_respack)
                report("beat with the request tag not acknowledged");

            if (walk_done)
            begin
                if (!pending)
                    report("walk_done with no walk in progress");
                else
                    compare_result();
                pending    = 1'b0;
                check_busy = 1'b1;
            end
        end
        reset_q = reset;
    end

endmodule

// File: ptw_tb.sv
`timescale 1ns/1ps
`include "ptw_macros.svh"

module ptw_tb;
    import mmu_pkg::*;
    import sysbus_pkg::*;

    localparam int NUM_TESTS  = 40;
    localparam int WAIT_LIMIT = 200;
    localparam bus_tag_t READ_TAG = {`SYSBUS_READ, `SYSBUS_MEMORY, 8'h00};

    logic                       clk;
    logic                       reset;
    logic                       translate_req;
    vaddr_t                     virt_addr;
    paddr_t                     ptbr;
    logic                       busy;
    logic                       walk_done;
    logic                       walk_fault;
    paddr_t                     phys_addr;
    pte_t [`LINE_BEATS-1:0]     pte_line;
    logic                       abtr_grant;
    logic                       abtr_reqcyc;
    logic                       bus_busy;
    logic                       main_bus_reqcyc;
    logic [`BUS_DATA_WIDTH-1:0] main_bus_req;
    bus_tag_t                   main_bus_reqtag;
    logic                       main_bus_respcyc;
    logic [`BUS_DATA_WIDTH-1:0] main_bus_resp;
    bus_tag_t                   main_bus_resptag;
    logic                       main_bus_respack;
    int                         check_errors;

    // Sparse page table memory keyed by 8-byte aligned byte address
    pte_t page_mem [paddr_t];

    logic [31:0] rng_state;
    int          tests_run;
    int          tests_failed;
    int          timeouts;
    logic        stuck;

    ptw_top dut_i (.*);

    ptw_checker checker_i (.*, .error_count(check_errors));

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic fill_line(input paddr_t line, input int sel, input pte_t sel_entry);
        int i;
        for (i = 0; i < `LINE_BEATS; i++)
        begin
            if (i == sel)
                page_mem[line + paddr_t'(i * 8)] = sel_entry;
            else
                page_mem[line + paddr_t'(i * 8)] = {xorshift32(), xorshift32()};
        end
    endtask

    // ====================
    // Bus and arbiter model
    // ====================
    task automatic serve_line(output logic ok);
        paddr_t      line;
        int          cycles;
        int          delay;
        int          sent;
        int          pick;
        logic [31:0] rnd;
        ok     = 1'b0;
        cycles = 0;
        @(posedge clk);
        while (!abtr_reqcyc)
        begin
            if (cycles == WAIT_LIMIT)
            begin
                $display("Timeout: no arbiter request from the walker within %0d cycles", cycles);
                return;
            end
            cycles++;
            @(posedge clk);
        end
        delay = int'(xorshift32() % 5);
        repeat (delay) @(posedge clk);
        abtr_grant <= 1'b1;
        @(posedge clk);
        abtr_grant <= 1'b0;
        cycles = 0;
        @(posedge clk);
        while (!main_bus_reqcyc)
        begin
            if (cycles == WAIT_LIMIT)
            begin
                $display("Timeout: no bus request followed the grant within %0d cycles", cycles);
                return;
            end
            cycles++;
            @(posedge clk);
        end
        line = main_bus_req;
        sent = 0;
        // Idle cycles and beats of another master are mixed into the line
        while (sent < `LINE_BEATS)
        begin
            pick = int'(xorshift32() % 8);
            if (pick == 0)
                main_bus_respcyc <= 1'b0;
            else if (pick == 1)
            begin
                rnd = xorshift32();
                main_bus_respcyc <= 1'b1;
                main_bus_resptag <= {`SYSBUS_READ, `SYSBUS_MEMORY, rnd[7:0] | 8'h01};
                main_bus_resp    <= {rnd, ~rnd};
            end
            else
            begin
                main_bus_respcyc <= 1'b1;
                main_bus_resptag <= READ_TAG;
                main_bus_resp    <= page_mem[line + paddr_t'(sent * 8)];
                sent++;
            end
            @(posedge clk);
        end
        main_bus_respcyc <= 1'b0;
        ok = 1'b1;
    endtask

    // ====================
    // One translation
    // ====================
    task automatic run_walk(input int t);
        vaddr_t      va;
        paddr_t      root;
        paddr_t      base;
        paddr_t      entry_addr;
        vpn_t        vpn;
        logic [43:0] ppn;
        logic [31:0] rnd;
        logic        valid;
        logic        drop;
        logic        ok;
        int          fault_level;
        int          levels;
        int          lvl;
        int          pick;
        int          errs_before;
        int          cycles;
        va          = {xorshift32(), xorshift32()};
        pick        = int'(xorshift32() % 6);
        fault_level = (pick < 3) ? 0 : pick - 2;
        drop        = (xorshift32() % 4 == 0);
        levels      = (fault_level == 0) ? `WALK_LEVELS : fault_level;
        page_mem.delete();

        // Table pages of levels 1 to 3 differ in their low page number bits
        rnd  = xorshift32();
        root = paddr_t'({rnd[19:0], 2'd1}) << 12;
        base = root;
        for (lvl = 1; lvl <= levels; lvl++)
        begin
            case (lvl)
                1:       vpn = va[38:30];
                2:       vpn = va[29:21];
                default: vpn = va[20:12];
            endcase
            entry_addr = base + paddr_t'({vpn, 3'b000});
            rnd        = xorshift32();
            if (lvl < `WALK_LEVELS)
                ppn = 44'({rnd[19:0], 2'(lvl + 1)});
            else
                ppn = {12'(xorshift32()), rnd};
            valid = (lvl != fault_level);
            fill_line({entry_addr[63:6], 6'b000000}, int'(entry_addr[5:3]),
                      {10'(xorshift32()), ppn, 9'(xorshift32()), valid});
            base = paddr_t'(ppn) << 12;
        end

        errs_before   = check_errors;
        translate_req <= 1'b1;
        virt_addr     <= va;
        ptbr          <= root;
        @(posedge clk);
        translate_req <= 1'b0;
        virt_addr     <= {xorshift32(), xorshift32()};
        if (drop)
        begin
            @(posedge clk);
            translate_req <= 1'b1;
            ptbr          <= paddr_t'(xorshift32()) << 12;
            @(posedge clk);
            translate_req <= 1'b0;
        end

        ok = 1'b1;
        for (lvl = 1; lvl <= levels && ok; lvl++)
            serve_line(ok);
        if (ok)
        begin
            cycles = 0;
            @(posedge clk);
            while (!walk_done && ok)
            begin
                if (cycles == WAIT_LIMIT)
                begin
                    $display("Timeout: walk_done did not arrive within %0d cycles", cycles);
                    ok = 1'b0;
                end
                else
                begin
                    cycles++;
                    @(posedge clk);
                end
            end
        end
        if (ok)
            repeat (2) @(posedge clk);
        else
        begin
            stuck = 1'b1;
            timeouts++;
        end

        tests_run++;
        if (ok && check_errors == errs_before)
            $display("test %0d: fault level %0d, dropped strobe %0d: pass", t, fault_level, drop);
        else
        begin
            tests_failed++;
            $display("test %0d: fault level %0d, dropped strobe %0d: fail, %0d check errors",
                     t, fault_level, drop, check_errors - errs_before);
        end
    endtask

    initial
    begin
        int t;
        int sva_failures;
        rng_state        = 32'hb4a0_ad8d;
        reset            = 1'b1;
        translate_req    = 1'b0;
        virt_addr        = '0;
        ptbr             = '0;
        abtr_grant       = 1'b0;
        main_bus_respcyc = 1'b0;
        main_bus_resp    = '0;
        main_bus_resptag = '0;
        tests_run        = 0;
        tests_failed     = 0;
        timeouts         = 0;
        stuck            = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        for (t = 0; t < NUM_TESTS && !stuck; t++)
            run_walk(t);

        sva_failures = int'(dut_i.port_i.sva_i.fail_count);
        $display("Tests %0d, failed %0d, check errors %0d, assertion failures %0d, timeouts %0d",
                 tests_run, tests_failed, check_errors, sva_failures, timeouts);
        if (tests_failed == 0 && check_errors == 0 && sva_failures == 0 && timeouts == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: build.f
+incdir+.
mmu_pkg.sv
sysbus_pkg.sv
walk_request_latch.sv
page_walker.sv
sysbus_port.sv
ptw_top.sv
ptw_sva.sv
ptw_checker.sv
ptw_tb.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         ?= ptw_tb
FILELIST    ?= build.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --binary --timing --assert
LINT_FLAGS  ?= --lint-only --timing --assert
ERROR_LIMIT ?= 100
PASS_TEXT   ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
